/* logic/lcd_pkg.sv */
package lcd_pkg;

	// clock cycles per microsecond
	localparam int CLK_PER_US = 25;

	localparam int POWERUP_US = 500;
	localparam int INIT_E_US = 10;
	localparam int WR_SETUP_US = 1;
	localparam int WR_HIGH_US = 13;
	localparam int WR_CYCLE_US = 50;

	typedef logic [6:0] lcd_cfg_t;       // lines, font, on, cursor, blink, inc/dec, shift
	typedef logic [9:0] lcd_word_t;      // rs, rw, data[7:0]
	typedef logic [7:0] lcd_byte_t;
	typedef logic [13:0] timer_count_t;  // delay in clock cycles
	typedef logic [1:0] init_step_t;

	localparam timer_count_t POWERUP_CYC = timer_count_t'(POWERUP_US * CLK_PER_US);
	localparam timer_count_t INIT_E_CYC = timer_count_t'(INIT_E_US * CLK_PER_US);
	localparam timer_count_t WR_SETUP_CYC = timer_count_t'(WR_SETUP_US * CLK_PER_US);
	localparam timer_count_t WR_HIGH_CYC = timer_count_t'(WR_HIGH_US * CLK_PER_US);
	// rest of the write cycle after setup and the high phase
	localparam timer_count_t WR_HOLD_CYC =
		timer_count_t'((WR_CYCLE_US - WR_SETUP_US - WR_HIGH_US) * CLK_PER_US);

	typedef enum logic [2:0] {
		POWER_UP,    // panel power-up delay
		INIT_PULSE,  // e high with init command
		INIT_WAIT,   // post-command wait
		READY,       // idle, accepts lcd_enable
		WR_SETUP,    // word on lines, e low
		WR_HIGH,     // enable pulse
		WR_HOLD      // e low until cycle end
	} ctrl_state_t;

endpackage

/* logic/lcd_delay_timer.sv */
module lcd_delay_timer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  load,
	input  lcd_pkg::timer_count_t len,
	output logic                  expired
);

	lcd_pkg::timer_count_t count;

	// count reaches zero len cycles after load
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;                                        // idle means expired
		end else if (load) begin
			count <= lcd_pkg::timer_count_t'(len - 1'b1);
		end else if (count != '0) begin
			count <= lcd_pkg::timer_count_t'(count - 1'b1);
		end
	end

	assign expired = (count == '0);  // held until next load

endmodule

/* logic/lcd_init_rom.sv */
module lcd_init_rom (
	input  lcd_pkg::init_step_t   step,
	input  lcd_pkg::lcd_cfg_t     cfg,
	output lcd_pkg::lcd_byte_t    cmd_byte,
	output lcd_pkg::timer_count_t wait_len
);

	// command byte per step, config bits dropped into place
	always_comb begin
		case (step)
			2'd0: cmd_byte = {4'b0011, cfg[6], cfg[5], 2'b00};   // function set
			2'd1: cmd_byte = {5'b00001, cfg[4], cfg[3], cfg[2]}; // display on/off
			2'd2: cmd_byte = 8'b0000_0001;                       // clear
			default: cmd_byte = {6'b000001, cfg[1], cfg[0]};    // entry mode
		endcase
	end

	// wait after each command, clear needs the longest
	always_comb begin
		case (step)
			2'd0: begin
				wait_len = lcd_pkg::timer_count_t'(50 * lcd_pkg::CLK_PER_US);
			end
			2'd1: begin
				wait_len = lcd_pkg::timer_count_t'(50 * lcd_pkg::CLK_PER_US);
			end
			2'd2: begin
				wait_len = lcd_pkg::timer_count_t'(200 * lcd_pkg::CLK_PER_US);
			end
			default: begin
				wait_len = lcd_pkg::timer_count_t'(100 * lcd_pkg::CLK_PER_US);
			end
		endcase
	end

endmodule

/* logic/lcd_bus_driver.sv */
module lcd_bus_driver (
	input  logic                clk,
	input  logic                rst,
	input  logic                load_init,
	input  logic                load_user,
	input  logic                clear,
	input  lcd_pkg::lcd_byte_t  cmd_byte,
	input  lcd_pkg::lcd_word_t  bus_word,
	output logic                rs,
	output logic                rw,
	output lcd_pkg::lcd_byte_t  lcd_data
);

	// lines hold their value between loads
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= '0;
		end else if (load_init) begin
			rs       <= 1'b0;            // init commands are instruction writes
			rw       <= 1'b0;
			lcd_data <= cmd_byte;
		end else if (load_user) begin
			rs       <= bus_word[9];
			rw       <= bus_word[8];     // passed through, nothing read back
			lcd_data <= bus_word[7:0];
		end
	end

endmodule

/* logic/lcd_ctrl.sv */
module lcd_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  lcd_enable,
	input  logic                  expired,
	input  lcd_pkg::timer_count_t wait_len,
	output lcd_pkg::init_step_t   step,
	output logic                  timer_load,
	output lcd_pkg::timer_count_t timer_len,
	output logic                  drv_load_init,
	output logic                  drv_load_user,
	output logic                  drv_clear,
	output logic                  e,
	output logic                  busy
);

	lcd_pkg::ctrl_state_t state;
	lcd_pkg::ctrl_state_t state_next;
	logic                 pwr_armed;  // power-up delay loaded

	always_comb begin
		state_next    = state;
		timer_load    = 1'b0;
		timer_len     = lcd_pkg::INIT_E_CYC;
		drv_load_init = 1'b0;
		drv_load_user = 1'b0;
		drv_clear     = 1'b0;
		case (state)
			lcd_pkg::POWER_UP: begin
				if (!pwr_armed) begin
					timer_load = 1'b1;                      // first cycle counts too
					timer_len  = lcd_pkg::timer_count_t'(lcd_pkg::POWERUP_CYC - 1'b1);
				end else if (expired) begin
					state_next    = lcd_pkg::INIT_PULSE;
					timer_load    = 1'b1;
					drv_load_init = 1'b1;
				end
			end
			lcd_pkg::INIT_PULSE: begin
				if (expired) begin
					state_next = lcd_pkg::INIT_WAIT;
					timer_load = 1'b1;
					timer_len  = wait_len;              // rom still on this step
					drv_clear  = 1'b1;
				end
			end
			lcd_pkg::INIT_WAIT: begin
				if (expired && step == '0) begin        // step wrapped after entry mode
					state_next = lcd_pkg::READY;
				end else if (expired) begin
					state_next    = lcd_pkg::INIT_PULSE;
					timer_load    = 1'b1;
					drv_load_init = 1'b1;
				end
			end
			lcd_pkg::READY: begin
				if (lcd_enable) begin
					state_next    = lcd_pkg::WR_SETUP;
					timer_load    = 1'b1;
					timer_len     = lcd_pkg::WR_SETUP_CYC;
					drv_load_user = 1'b1;
				end
			end
			lcd_pkg::WR_SETUP: begin
				if (expired) begin
					state_next = lcd_pkg::WR_HIGH;
					timer_load = 1'b1;
					timer_len  = lcd_pkg::WR_HIGH_CYC;
				end
			end
			lcd_pkg::WR_HIGH: begin
				if (expired) begin
					state_next = lcd_pkg::WR_HOLD;
					timer_load = 1'b1;
					timer_len  = lcd_pkg::WR_HOLD_CYC;
				end
			end
			default: begin                              // WR_HOLD
				if (expired) begin
					state_next = lcd_pkg::READY;
					drv_clear  = 1'b1;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= lcd_pkg::POWER_UP;
			pwr_armed <= 1'b0;
			step      <= '0;
			e         <= 1'b0;
		end else begin
			state     <= state_next;
			pwr_armed <= 1'b1;
			if (state == lcd_pkg::INIT_PULSE && expired)
				step <= lcd_pkg::init_step_t'(step + 1'b1);  // next command during wait
			e <= (state_next == lcd_pkg::INIT_PULSE) || (state_next == lcd_pkg::WR_HIGH);
		end
	end

	assign busy = (state != lcd_pkg::READY);

endmodule

/* logic/lcd_top.sv */
module lcd_top (
	input  logic               clk,
	input  logic               rst,
	input  lcd_pkg::lcd_cfg_t  cfg,
	input  logic               lcd_enable,
	input  lcd_pkg::lcd_word_t lcd_bus,
	output logic               e,
	output lcd_pkg::lcd_byte_t lcd_data,
	output logic               rw,
	output logic               rs,
	output logic               busy
);

	logic                  expired;
	logic                  timer_load;
	lcd_pkg::timer_count_t timer_len;
	lcd_pkg::timer_count_t wait_len;
	lcd_pkg::init_step_t   step;
	lcd_pkg::lcd_byte_t    cmd_byte;
	logic                  drv_load_init;
	logic                  drv_load_user;
	logic                  drv_clear;

	lcd_ctrl i_lcd_ctrl (
		.clk           (clk),
		.rst           (rst),
		.lcd_enable    (lcd_enable),
		.expired       (expired),
		.wait_len      (wait_len),
		.step          (step),
		.timer_load    (timer_load),
		.timer_len     (timer_len),
		.drv_load_init (drv_load_init),
		.drv_load_user (drv_load_user),
		.drv_clear     (drv_clear),
		.e             (e),
		.busy          (busy)
	);

	lcd_delay_timer i_lcd_delay_timer (
		.clk     (clk),
		.rst     (rst),
		.load    (timer_load),
		.len     (timer_len),
		.expired (expired)
	);

	lcd_init_rom i_lcd_init_rom (
		.step     (step),
		.cfg      (cfg),
		.cmd_byte (cmd_byte),
		.wait_len (wait_len)
	);

	lcd_bus_driver i_lcd_bus_driver (
		.clk       (clk),
		.rst       (rst),
		.load_init (drv_load_init),
		.load_user (drv_load_user),
		.clear     (drv_clear),
		.cmd_byte  (cmd_byte),
		.bus_word  (lcd_bus),
		.rs        (rs),
		.rw        (rw),
		.lcd_data  (lcd_data)
	);

endmodule

/* verification/tb_clock_gen.sv */
module tb_clock_gen (
	output logic clk
);

	initial clk = 1'b0;

	always #5 clk = ~clk;  // 10 unit period

endmodule

/* verification/lcd_checker.sv */
module lcd_checker (
	input logic                 clk,
	input logic                 rst,
	input logic                 lcd_enable,
	input lcd_pkg::ctrl_state_t state,
	input logic                 e,
	input logic                 busy
);

	int fail_count = 0;  // read by the testbench

	ready_holds: assert property (@(posedge clk) disable iff (rst)
		(state == lcd_pkg::READY && !lcd_enable) |=> (state == lcd_pkg::READY))
		else begin
			fail_count++;
			$error("state left READY without lcd_enable");
		end

	e_only_in_pulse: assert property (@(posedge clk) disable iff (rst)
		e |-> (state == lcd_pkg::INIT_PULSE || state == lcd_pkg::WR_HIGH))
		else begin
			fail_count++;
			$error("e high outside INIT_PULSE and WR_HIGH");
		end

	// READY is only reached when init or a write cycle ends
	busy_drop_at_end: assert property (@(posedge clk) disable iff (rst)
		$fell(busy) |-> $past(state == lcd_pkg::WR_HOLD || state == lcd_pkg::INIT_WAIT))
		else begin
			fail_count++;
			$error("busy dropped before the end of an init or write cycle");
		end

endmodule

/* verification/tb_lcd.sv */
module tb_lcd;

	localparam int POWERUP_CYCLES = lcd_pkg::POWERUP_US * lcd_pkg::CLK_PER_US;
	localparam int INIT_E_CYCLES = lcd_pkg::INIT_E_US * lcd_pkg::CLK_PER_US;
	localparam int WR_SETUP_CYCLES = lcd_pkg::WR_SETUP_US * lcd_pkg::CLK_PER_US;
	localparam int WR_HIGH_CYCLES = lcd_pkg::WR_HIGH_US * lcd_pkg::CLK_PER_US;
	localparam int WR_CYCLE_CYCLES = lcd_pkg::WR_CYCLE_US * lcd_pkg::CLK_PER_US;
	// four pulses plus the waits after function set, display, clear, entry mode
	localparam int INIT_CYCLES = 4 * INIT_E_CYCLES + (50 + 50 + 200 + 100) * lcd_pkg::CLK_PER_US;
	localparam int IDLE_CYCLES = 200;
	localparam int MAX_GAP = 15;  // 4 random bits

	logic               clk;
	logic               rst;
	lcd_pkg::lcd_cfg_t  cfg;
	logic               lcd_enable;
	lcd_pkg::lcd_word_t lcd_bus;
	logic               e;
	lcd_pkg::lcd_byte_t lcd_data;
	logic               rw;
	logic               rs;
	logic               busy;

	logic [15:0] trace_mem [0:63];
	bit          trace_loaded = 1'b0;
	int          n_writes;
	logic [31:0] lfsr_state = 32'h8675_101f;

	// filled by the bus monitor
	lcd_pkg::lcd_word_t pulse_word[$];   // {rs, rw, data} at each rising e
	int                 pulse_len[$];
	int                 write_busy_len[$];
	int                 write_setup_len[$];

	tb_clock_gen i_tb_clock_gen (
		.clk (clk)
	);

	lcd_top i_lcd_top (
		.clk        (clk),
		.rst        (rst),
		.cfg        (cfg),
		.lcd_enable (lcd_enable),
		.lcd_bus    (lcd_bus),
		.e          (e),
		.lcd_data   (lcd_data),
		.rw         (rw),
		.rs         (rs),
		.busy       (busy)
	);

	bind lcd_ctrl lcd_checker i_lcd_checker (
		.clk        (clk),
		.rst        (rst),
		.lcd_enable (lcd_enable),
		.state      (state),
		.e          (e),
		.busy       (busy)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
			abort_run($sformatf("[ERROR] %s: expected %0h, actual %0h", name, expected, actual));
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_gap(output int gap);
		gap = 0;
		repeat (4) begin
			lfsr_state = lfsr_next(lfsr_state);
			gap = (gap << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic wait_ready;
		@(negedge clk);
		while (busy) @(negedge clk);
		#1;  // monitor has pushed its lengths by now
	endtask

	task automatic idle_check(input int n);
		repeat (n) begin
			@(negedge clk);
			check_value("no e pulse when idle", 32'd0, 32'(e));
			check_value("busy low when idle", 32'd0, 32'(busy));
		end
	endtask

	task automatic write_word(input lcd_pkg::lcd_word_t word);
		@(posedge clk);
		#1;
		check_value("ready before write", 32'd0, 32'(busy));
		lcd_bus    = word;
		lcd_enable = 1'b1;
		@(posedge clk);
		#1 lcd_enable = 1'b0;
		repeat (60) @(posedge clk);
		#1 lcd_bus = ~word;  // stray strobe during e high
		lcd_enable = 1'b1;
		repeat (2) @(posedge clk);
		#1 lcd_enable = 1'b0;
		repeat (300) @(posedge clk);
		#1 lcd_enable = 1'b1;  // another one in the hold phase
		@(posedge clk);
		#1 lcd_enable = 1'b0;
		wait_ready();
	endtask

	// bus monitor, samples away from the clock edge
	logic e_prev;
	logic busy_prev;
	bit   init_done;
	int   e_len;
	int   busy_len;
	lcd_pkg::lcd_word_t hold_word;

	always @(negedge clk) begin
		if (rst) begin
			e_prev    = 1'b0;
			busy_prev = 1'b1;
			init_done = 1'b0;
		end else begin
			if (e && !e_prev) begin
				pulse_word.push_back({rs, rw, lcd_data});
				e_len = 1;
				if (init_done)
					write_setup_len.push_back(busy_len);
			end else if (e) begin
				e_len++;
				check_value("lines stable in e pulse", 32'(pulse_word[$]), 32'({rs, rw, lcd_data}));
			end else if (e_prev) begin
				pulse_len.push_back(e_len);
			end
			if (!init_done && !e)
				check_value("data low between init pulses", 32'd0, 32'(lcd_data));
			if (init_done && busy) begin
				if (!busy_prev) begin
					busy_len  = 1;
					hold_word = {rs, rw, lcd_data};
				end else begin
					busy_len++;
					check_value("lines stable while busy", 32'(hold_word), 32'({rs, rw, lcd_data}));
				end
			end else if (init_done && busy_prev) begin
				write_busy_len.push_back(busy_len);
			end
			if (!busy)
				init_done = 1'b1;
			e_prev    = e;
			busy_prev = busy;
		end
	end

	always @(negedge clk) begin
		if (i_lcd_top.i_lcd_ctrl.i_lcd_checker.fail_count != 0)
			abort_run("a concurrent assertion on the control FSM failed");
	end

	initial begin : watchdog
		int limit;
		wait (trace_loaded);
		limit = 10 + POWERUP_CYCLES + INIT_CYCLES + 2 * IDLE_CYCLES
			+ n_writes * (WR_CYCLE_CYCLES + MAX_GAP + 4) + 1000;
		repeat (limit) @(posedge clk);
		abort_run($sformatf("timeout: the DUT did not finish within %0d clock cycles", limit));
	end

	initial begin
		int                 cycles;
		int                 gap;
		lcd_pkg::lcd_word_t word;
		rst        = 1'b1;
		lcd_enable = 1'b0;
		lcd_bus    = '0;
		cfg        = '0;
		$readmemh("verification/lcd_trace.txt", trace_mem);
		cfg          = trace_mem[0][6:0];
		n_writes     = int'(trace_mem[5]);
		trace_loaded = 1'b1;
		repeat (10) @(posedge clk);
		#1 rst = 1'b0;

		@(negedge clk);
		check_value("e after reset", 32'd0, 32'(e));
		check_value("busy after reset", 32'd1, 32'(busy));
		check_value("lines after reset", 32'd0, 32'({rs, rw, lcd_data}));
		cycles = 0;
		while (!e) begin
			check_value("busy during power-up", 32'd1, 32'(busy));
			cycles++;
			@(negedge clk);
		end
		check_value("power-up length", POWERUP_CYCLES, cycles);
		cycles = 0;
		while (busy) begin
			cycles++;
			@(negedge clk);
		end
		check_value("init length", INIT_CYCLES, cycles);
		#1;
		check_value("init pulse count", 32'd4, pulse_word.size());
		for (int i = 0; i < 4; i++) begin
			check_value($sformatf("init command %0d", i), {24'd0, trace_mem[1 + i][7:0]},
				32'(pulse_word[i]));  // rs and rw must be low too
			check_value($sformatf("init pulse %0d length", i), INIT_E_CYCLES, pulse_len[i]);
		end
		idle_check(IDLE_CYCLES);

		for (int i = 0; i < n_writes; i++) begin
			random_gap(gap);
			repeat (gap) @(posedge clk);
			word = trace_mem[6 + i][9:0];
			write_word(word);
			check_value($sformatf("e pulse count after write %0d", i), 5 + i, pulse_word.size());
			check_value($sformatf("write %0d bus word", i), 32'(word), 32'(pulse_word[4 + i]));
			check_value($sformatf("write %0d e length", i), WR_HIGH_CYCLES, pulse_len[4 + i]);
			check_value($sformatf("write %0d setup length", i), WR_SETUP_CYCLES,
				write_setup_len[i]);
			check_value($sformatf("write %0d busy length", i), WR_CYCLE_CYCLES, write_busy_len[i]);
		end
		idle_check(IDLE_CYCLES);

		if (i_lcd_top.i_lcd_ctrl.i_lcd_checker.fail_count == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			abort_run("a concurrent assertion on the control FSM failed");
		end
	end

endmodule

/* verification/lcd_trace.txt */
// one hex value per line: cfg word (lines font on cursor blink inc shift),
// four expected init command bytes, number of writes, then {rs, rw, data} words
5a
38
0e
01
06
8
248
265
26c
26c
26f
0c0
357
121

/* list.f */
logic/lcd_pkg.sv
logic/lcd_delay_timer.sv
logic/lcd_init_rom.sv
logic/lcd_bus_driver.sv
logic/lcd_ctrl.sv
logic/lcd_top.sv
verification/tb_clock_gen.sv
verification/lcd_checker.sv
verification/tb_lcd.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run tb_lcd and check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -f list.f --top-module tb_lcd
	./obj_dir/Vtb_lcd +verilator+error+limit+100 2>&1 | tee $(LOG)
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
